// File: tb/core_tests.txt
// First value is the number of tests, all values hex
// Columns: instr rd wen data illegal
18
00500093 01 1 0000000000000005 0 // addi x1, x0, 5
ffd00113 02 1 fffffffffffffffd 0 // addi x2, x0, -3
002081b3 03 1 0000000000000002 0 // add x3, x1, x2
40208233 04 1 0000000000000008 0 // sub x4, x1, x2
0020f2b3 05 1 0000000000000005 0 // and x5, x1, x2
0020e333 06 1 fffffffffffffffd 0 // or x6, x1, x2
0020c3b3 07 1 fffffffffffffff8 0 // xor x7, x1, x2
00409433 08 1 0000000000000500 0 // sll x8, x1, x4
004154b3 09 1 00ffffffffffffff 0 // srl x9, x2, x4
40415533 0a 1 ffffffffffffffff 0 // sra x10, x2, x4
001125b3 0b 1 0000000000000001 0 // slt x11, x2, x1
00113633 0c 1 0000000000000000 0 // sltu x12, x2, x1
800006b7 0d 1 ffffffff80000000 0 // lui x13, 0x80000
10000713 0e 1 0000000000000100 0 // addi x14, x0, 0x100
00d73423 00 0 0000000000000108 0 // sd x13, 8(x14)
00873783 0f 1 ffffffff80000000 0 // ld x15, 8(x14)
00473823 00 0 0000000000000110 0 // sd x4, 16(x14)
01073a03 14 1 0000000000000008 0 // ld x20, 16(x14)
021080b3 01 0 0000000000000000 1 // mul x1, x1, x1 is not supported
00008813 10 1 0000000000000005 0 // addi x16, x1, 0
00708013 00 1 000000000000000c 0 // addi x0, x1, 7
000008b3 11 1 0000000000000000 0 // add x17, x0, x0
00873903 12 1 ffffffff80000000 0 // ld x18, 8(x14)
001909b3 13 1 ffffffff80000005 0 // add x19, x18, x1

// File: vlog.f
hdl/core_pkg.sv
hdl/core_stage_reg.sv
hdl/core_regfile.sv
hdl/core_decode.sv
hdl/core_execute.sv
hdl/core_result.sv
hdl/core_top.sv
tb/tb_clock.sv
tb/core_assert.sv
tb/core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f vlog.f --top-module core_tb -Mdir "$build_dir" -o core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/core_sim" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qF '** PASS **' "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1

// File: tb/core_tb.sv
`timescale 1ns/10ps

module core_tb;
    import core_pkg::*;

    localparam int max_tests = 32;
    localparam int fields    = 5;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic        instr_ready;
    logic [31:0] instr;
    logic        mem_req_valid;
    logic        mem_req_ready;
    mem_req_t    mem_req;
    logic        mem_rsp_valid;
    word_t       mem_rdata;
    logic        retire_valid;
    logic        retire_ready;
    retire_t     retire;

    // Test count in entry 0, then instr, rd, wen, data and illegal for each test
    logic [63:0] vec [fields*max_tests+1];
    word_t       mem [word_t];

    int          seed = 52166;
    int          n_tests;
    int          sent;
    int          done;
    int          cycles;
    int          limit;
    logic [31:0] rnd;
    logic        rsp_pending;
    logic [1:0]  rsp_delay;
    word_t       rsp_data;

    tb_clock u_clock (.clk(clk));

    core_top u_dut (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr_ready(instr_ready), .instr(instr),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
        .mem_rsp_valid(mem_rsp_valid), .mem_rdata(mem_rdata),
        .retire_valid(retire_valid), .retire_ready(retire_ready), .retire(retire)
    );

    // Locations never stored to give a pattern built from the address
    function automatic word_t mem_read(input word_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return ~{addr[31:0], addr[63:32]};
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "retire record mismatch");
        end
    endtask

    task automatic check_retire(input int k);
        int base;
        base = 1 + fields*k;
        check($sformatf("retire.rd (test %0d)", k), {59'b0, retire.rd}, vec[base+1]);
        check($sformatf("retire.wen (test %0d)", k), {63'b0, retire.wen}, vec[base+2]);
        check($sformatf("retire.data (test %0d)", k), retire.data, vec[base+3]);
        check($sformatf("retire.illegal (test %0d)", k), {63'b0, retire.illegal}, vec[base+4]);
    endtask

    // Inputs for the coming rising edge
    // Both ready signals stall at random
    task automatic drive_inputs();
        rnd           = $random(seed);
        retire_ready  = rnd[1:0] != 2'b00;
        mem_req_ready = rnd[3:2] != 2'b00;
        mem_rsp_valid = 1'b0;
        if (rsp_pending) begin
            if (rsp_delay == 2'd0) begin
                mem_rsp_valid = 1'b1;
                mem_rdata     = rsp_data;
                rsp_pending   = 1'b0;
            end else begin
                rsp_delay = rsp_delay - 2'd1;
            end
        end
        instr_valid = sent < n_tests;
        if (sent < n_tests) begin
            instr = vec[1 + fields*sent][31:0];
        end
    endtask

    // Handshakes that the coming rising edge completes
    task automatic observe();
        if (instr_valid && instr_ready) begin
            sent++;
        end
        if (mem_req_valid && mem_req_ready) begin
            if (mem_req.write) begin
                mem[mem_req.addr] = mem_req.wdata;
            end else begin
                rnd         = $random(seed);
                rsp_pending = 1'b1;
                rsp_delay   = rnd[1:0];
                rsp_data    = mem_read(mem_req.addr);
            end
        end
        if (retire_valid && retire_ready) begin
            check_retire(done);
            done++;
        end
    endtask

    initial begin
        rst           = 1'b0;
        instr_valid   = 1'b0;
        instr         = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rdata     = '0;
        retire_ready  = 1'b0;
        rsp_pending   = 1'b0;
        rsp_delay     = '0;
        rsp_data      = '0;
        sent          = 0;
        done          = 0;
        cycles        = 0;
        $readmemh("tb/core_tests.txt", vec);
        n_tests = int'(vec[0]);
        if (n_tests < 1 || n_tests > max_tests) begin
            n_tests = 0;
        end
        limit = n_tests*20 + 100;

        repeat (16) @(negedge clk);
        rst = 1'b1;

        while (n_tests > 0 && done < n_tests && cycles <= limit) begin
            @(negedge clk);
            drive_inputs();
            #1;
            observe();
            cycles++;
        end

        if (n_tests > 0 && done == n_tests) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("Run stopped after %0d cycles with %0d of %0d records retired",
                     cycles, done, n_tests);
            $display("** FAIL **");
            $fatal(1, "timeout or unreadable test file");
        end
    end

endmodule

// File: tb/core_assert.sv
`timescale 1ns/10ps

module core_assert (
    input logic               clk,
    input logic               rst,
    input logic               instr_valid,
    input logic               instr_ready,
    input logic [31:0]        instr,
    input logic               mem_req_valid,
    input logic               mem_req_ready,
    input core_pkg::mem_req_t mem_req,
    input logic               retire_valid,
    input logic               retire_ready,
    input core_pkg::retire_t  retire
);

    a_instr_hold: assert property (@(posedge clk) disable iff (!rst)
        instr_valid && !instr_ready |=> instr_valid && $stable(instr))
        else $error("instruction dropped or changed before its handshake");

    a_req_hold: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("memory request dropped or changed before its handshake");

    a_retire_hold: assert property (@(posedge clk) disable iff (!rst)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire))
        else $error("retire record dropped or changed before its handshake");

    // Outputs go quiet one edge into reset
    a_reset_quiet: assert property (@(posedge clk)
        !rst |=> !retire_valid && !mem_req_valid)
        else $error("valid output high during reset");

endmodule

bind core_top core_assert u_assert (
    .clk(clk), .rst(rst),
    .instr_valid(instr_valid), .instr_ready(instr_ready), .instr(instr),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
    .retire_valid(retire_valid), .retire_ready(retire_ready), .retire(retire)
);

// File: tb/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int period_ns = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Free running, first rising edge at half a period
    always #(period_ns / 2) clk = ~clk;

endmodule

// File: hdl/core_top.sv
`timescale 1ns/10ps

module core_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    output logic               instr_ready,
    input  logic [31:0]        instr,
    output logic               mem_req_valid,
    input  logic               mem_req_ready,
    output core_pkg::mem_req_t mem_req,
    input  logic               mem_rsp_valid,
    input  core_pkg::word_t    mem_rdata,
    output logic               retire_valid,
    input  logic               retire_ready,
    output core_pkg::retire_t  retire
);
    import core_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      rs1_busy;
    logic      rs2_busy;
    logic      set_valid;
    reg_addr_t set_rd;
    logic      wr_valid;
    reg_addr_t wr_rd;
    word_t     wr_data;

    // Decode to stage A
    logic    dec_valid;
    logic    dec_ready;
    dec_ex_t dec_data;
    // Stage A to execute
    logic    a_valid;
    logic    a_ready;
    dec_ex_t a_data;
    // Execute to stage B
    logic    ex_valid;
    logic    ex_ready;
    ex_res_t ex_data;
    // Stage B to result
    logic    b_valid;
    logic    b_ready;
    ex_res_t b_data;

    core_decode u_decode (
        .instr_valid(instr_valid), .instr_ready(instr_ready), .instr(instr),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_busy(rs1_busy), .rs2_busy(rs2_busy),
        .set_valid(set_valid), .set_rd(set_rd),
        .out_valid(dec_valid), .out_ready(dec_ready), .out_data(dec_data)
    );

    core_stage_reg #(.payload_t(dec_ex_t)) u_stage_a (
        .clk(clk), .rst(rst),
        .in_valid(dec_valid), .in_ready(dec_ready), .in_data(dec_data),
        .out_valid(a_valid), .out_ready(a_ready), .out_data(a_data)
    );

    core_execute u_execute (
        .in_valid(a_valid), .in_ready(a_ready), .in_data(a_data),
        .out_valid(ex_valid), .out_ready(ex_ready), .out_data(ex_data)
    );

    core_stage_reg #(.payload_t(ex_res_t)) u_stage_b (
        .clk(clk), .rst(rst),
        .in_valid(ex_valid), .in_ready(ex_ready), .in_data(ex_data),
        .out_valid(b_valid), .out_ready(b_ready), .out_data(b_data)
    );

    core_result u_result (
        .clk(clk), .rst(rst),
        .in_valid(b_valid), .in_ready(b_ready), .in_data(b_data),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
        .mem_rsp_valid(mem_rsp_valid), .mem_rdata(mem_rdata),
        .wr_valid(wr_valid), .wr_rd(wr_rd), .wr_data(wr_data),
        .retire_valid(retire_valid), .retire_ready(retire_ready), .retire(retire)
    );

    core_regfile u_regfile (
        .clk(clk), .rst(rst),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_busy(rs1_busy), .rs2_busy(rs2_busy),
        .set_valid(set_valid), .set_rd(set_rd),
        .wr_valid(wr_valid), .wr_rd(wr_rd), .wr_data(wr_data)
    );

endmodule

// File: hdl/core_result.sv
`timescale 1ns/10ps

module core_result (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  core_pkg::ex_res_t   in_data,
    output logic                mem_req_valid,
    input  logic                mem_req_ready,
    output core_pkg::mem_req_t  mem_req,
    input  logic                mem_rsp_valid,
    input  core_pkg::word_t     mem_rdata,
    output logic                wr_valid,
    output core_pkg::reg_addr_t wr_rd,
    output core_pkg::word_t     wr_data,
    output logic                retire_valid,
    input  logic                retire_ready,
    output core_pkg::retire_t   retire
);
    import core_pkg::*;

    typedef enum logic [1:0] {st_idle, st_req, st_wait, st_retire} state_t;

    state_t  state;
    ex_res_t cur;
    retire_t ret;
    logic    take;
    logic    req_fire;
    logic    ret_fire;

    assign retire_valid = (state == st_retire);
    assign retire       = ret;
    assign ret_fire     = retire_valid && retire_ready;

    // Next instruction may enter while the current record leaves
    assign in_ready = (state == st_idle) || ret_fire;
    assign take     = in_valid && in_ready;

    assign mem_req_valid = (state == st_req);
    assign mem_req.write = (cur.mem_kind == store);
    assign mem_req.addr  = cur.result;
    assign mem_req.wdata = cur.store_data;
    assign req_fire      = mem_req_valid && mem_req_ready;

    assign wr_valid = ret_fire && ret.wen;
    assign wr_rd    = ret.rd;
    assign wr_data  = ret.data;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle, st_retire: begin
                    if (take) begin
                        state <= (in_data.mem_kind == none) ? st_retire : st_req;
                    end else if (ret_fire) begin
                        state <= st_idle;
                    end
                end
                st_req: begin
                    if (req_fire) begin
                        state <= (cur.mem_kind == store) ? st_retire : st_wait;
                    end
                end
                st_wait: begin
                    if (mem_rsp_valid) begin
                        state <= st_retire;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Record is built on entry, load data replaces the address later
    always_ff @(posedge clk) begin
        if (take) begin
            cur         <= in_data;
            ret.rd      <= in_data.rd;
            ret.wen     <= in_data.wen;
            ret.data    <= in_data.result;
            ret.illegal <= in_data.illegal;
        end else if (state == st_wait && mem_rsp_valid) begin
            ret.data <= mem_rdata;
        end
    end

endmodule

// File: hdl/core_execute.sv
`timescale 1ns/10ps

module core_execute (
    input  logic              in_valid,
    output logic              in_ready,
    input  core_pkg::dec_ex_t in_data,
    output logic              out_valid,
    input  logic              out_ready,
    output core_pkg::ex_res_t out_data
);
    import core_pkg::*;

    word_t              op_a;
    word_t              op_b;
    word_t              alu_res;
    word_t              addr;
    logic [shamt_w-1:0] shamt;

    assign op_a  = in_data.a;
    assign op_b  = in_data.b;
    assign shamt = op_b[shamt_w-1:0];

    always_comb begin
        case (in_data.alu_op)
            add:     alu_res = op_a + op_b;
            sub:     alu_res = op_a - op_b;
            and_op:  alu_res = op_a & op_b;
            or_op:   alu_res = op_a | op_b;
            xor_op:  alu_res = op_a ^ op_b;
            sll:     alu_res = op_a << shamt;
            srl:     alu_res = op_a >> shamt;
            sra:     alu_res = word_t'($signed(op_a) >>> shamt);
            slt:     alu_res = word_t'($signed(op_a) < $signed(op_b));
            sltu:    alu_res = word_t'(op_a < op_b);
            pass_b:  alu_res = op_b;
            default: alu_res = op_a + op_b;
        endcase
    end

    // Base plus offset for LD and SD
    assign addr = op_a + op_b;

    always_comb begin
        out_data            = '0;
        out_data.result     = (in_data.mem_kind != none) ? addr : alu_res;
        out_data.store_data = in_data.store_data;
        out_data.mem_kind   = in_data.mem_kind;
        out_data.rd         = in_data.rd;
        out_data.wen        = in_data.wen;
        out_data.illegal    = in_data.illegal;
    end

    assign out_valid = in_valid;
    assign in_ready  = out_ready;

endmodule

// File: hdl/core_decode.sv
`timescale 1ns/10ps

module core_decode (
    input  logic                instr_valid,
    output logic                instr_ready,
    input  logic [31:0]         instr,
    output core_pkg::reg_addr_t rs1,
    output core_pkg::reg_addr_t rs2,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    input  logic                rs1_busy,
    input  logic                rs2_busy,
    output logic                set_valid,
    output core_pkg::reg_addr_t set_rd,
    output logic                out_valid,
    input  logic                out_ready,
    output core_pkg::dec_ex_t   out_data
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;
    logic       use_rs1;
    logic       use_rs2;
    logic       legal;
    logic       stall;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};

    always_comb begin
        out_data    = '0;
        out_data.rd = rd;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        legal       = 1'b0;
        case (opcode)
            opc_op: begin
                use_rs1      = 1'b1;
                use_rs2      = 1'b1;
                out_data.a   = rs1_data;
                out_data.b   = rs2_data;
                out_data.wen = 1'b1;
                legal = (funct7 == f7_base) ||
                        (funct7 == f7_alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra));
                case (funct3)
                    f3_add_sub: out_data.alu_op = (funct7 == f7_alt) ? sub : add;
                    f3_sll:     out_data.alu_op = sll;
                    f3_slt:     out_data.alu_op = slt;
                    f3_sltu:    out_data.alu_op = sltu;
                    f3_xor:     out_data.alu_op = xor_op;
                    f3_srl_sra: out_data.alu_op = (funct7 == f7_alt) ? sra : srl;
                    f3_or:      out_data.alu_op = or_op;
                    f3_and:     out_data.alu_op = and_op;
                endcase
            end
            opc_op_imm: begin
                // ADDI only
                use_rs1      = 1'b1;
                out_data.a   = rs1_data;
                out_data.b   = imm_i;
                out_data.wen = 1'b1;
                legal        = (funct3 == f3_add_sub);
            end
            opc_lui: begin
                out_data.b      = imm_u;
                out_data.alu_op = pass_b;
                out_data.wen    = 1'b1;
                legal           = 1'b1;
            end
            opc_load: begin
                use_rs1           = 1'b1;
                out_data.a        = rs1_data;
                out_data.b        = imm_i;
                out_data.mem_kind = load;
                out_data.wen      = 1'b1;
                legal             = (funct3 == f3_dword);
            end
            opc_store: begin
                use_rs1             = 1'b1;
                use_rs2             = 1'b1;
                out_data.a          = rs1_data;
                out_data.b          = imm_s;
                out_data.store_data = rs2_data;
                out_data.mem_kind   = store;
                out_data.rd         = '0;
                legal               = (funct3 == f3_dword);
            end
            default: legal = 1'b0;
        endcase

        // Illegal ones travel down as a bare marker
        if (!legal) begin
            out_data         = '0;
            out_data.rd      = rd;
            out_data.illegal = 1'b1;
            use_rs1          = 1'b0;
            use_rs2          = 1'b0;
        end
    end

    assign stall       = (use_rs1 && rs1_busy) || (use_rs2 && rs2_busy);
    assign out_valid   = instr_valid && !stall;
    assign instr_ready = out_ready && !stall;

    assign set_valid = instr_valid && instr_ready && out_data.wen;
    assign set_rd    = out_data.rd;

endmodule

// File: hdl/core_regfile.sv
`timescale 1ns/10ps

module core_regfile (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    output logic                rs1_busy,
    output logic                rs2_busy,
    input  logic                set_valid,
    input  core_pkg::reg_addr_t set_rd,
    input  logic                wr_valid,
    input  core_pkg::reg_addr_t wr_rd,
    input  core_pkg::word_t     wr_data
);
    import core_pkg::*;

    word_t      regs [nregs];
    // Outstanding writes per register, at most three in flight
    logic [1:0] pend_cnt [nregs];

    always_ff @(posedge clk) begin
        if (wr_valid && wr_rd != '0) begin
            regs[wr_rd] <= wr_data;
        end
    end

    // x0 is skipped so it never goes pending
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < nregs; i++) begin
                pend_cnt[i] <= '0;
            end
        end else begin
            for (int i = 1; i < nregs; i++) begin
                case ({set_valid && set_rd == reg_addr_t'(i), wr_valid && wr_rd == reg_addr_t'(i)})
                    2'b10:   pend_cnt[i] <= pend_cnt[i] + 2'd1;
                    2'b01:   pend_cnt[i] <= pend_cnt[i] - 2'd1;
                    default: pend_cnt[i] <= pend_cnt[i];
                endcase
            end
        end
    end

    // No bypass, decode waits for the pending count to drop
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];
    assign rs1_busy = |pend_cnt[rs1];
    assign rs2_busy = |pend_cnt[rs2];

endmodule

// File: hdl/core_stage_reg.sv
`timescale 1ns/10ps

module core_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Slot can take new data when empty or being drained this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// File: hdl/core_pkg.sv
package core_pkg;

    localparam int xlen    = 64;
    localparam int nregs   = 32;
    localparam int shamt_w = 6;

    // Major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;

    // funct3 values for OP, ADDI and the doubleword memory access
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_dword   = 3'b011;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    typedef enum logic [3:0] {
        add, sub, and_op, or_op, xor_op, sll, srl, sra, slt, sltu, pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        none, load, store
    } mem_kind_t;

    // Decode to execute
    typedef struct packed {
        word_t     a;
        word_t     b;
        word_t     store_data;
        alu_op_t   alu_op;
        mem_kind_t mem_kind;
        reg_addr_t rd;
        logic      wen;
        logic      illegal;
    } dec_ex_t;

    // Execute to result, result holds the ALU value or the memory address
    typedef struct packed {
        word_t     result;
        word_t     store_data;
        mem_kind_t mem_kind;
        reg_addr_t rd;
        logic      wen;
        logic      illegal;
    } ex_res_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      wen;
        word_t     data;
        logic      illegal;
    } retire_t;

    typedef struct packed {
        logic  write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

endpackage
